// ==== sources.f ====
+incdir+.
fib_pkg.sv
fib_if.sv
fib_rx_parser.sv
fib_bitmap_table.sv
fib_lpm_engine.sv
fib_tx_serializer.sv
fib_top.sv
tb_fib_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the FIB testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_fib_top -f sources.f -o sim_fib; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_fib)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF '*** TEST PASSED ***' <<< "$output"; then
    exit 0
fi
exit 1

// ==== tb_fib_top.sv ====
//############################
// Directed testbench for the FIB block
// Own mask/hash model predicts notices and result streams
// Run as top module tb_fib_top
//############################
`include "fib_params.svh"
`default_nettype none

module tb_fib_top;
    timeunit 1ns;
    timeprecision 100ps;

    // Worst lookup walks all 64 lengths at 2 cycles each, plus the stream
    localparam int lookup_cycles = 2 * `FIB_LENGTHS + 40;
    localparam int packet_cycles = 40;
    localparam int num_lookups = 24;
    localparam int num_packets = 23;
    localparam int watchdog_cycles =
        2 * (16 + num_lookups * lookup_cycles + num_packets * packet_cycles);

    logic clk;
    logic rst;
    logic rx_valid;
    logic [7:0] rx_byte;
    logic notice_valid;
    logic [7:0] notice_metadata;
    logic [`FIB_PREFIX_W-1:0] notice_prefix;
    logic lookup_valid;
    logic lookup_ready;
    logic [7:0] lookup_metadata;
    logic [`FIB_PREFIX_W-1:0] lookup_prefix;
    logic tx_valid;
    logic [7:0] tx_byte;

    // Reference table and traffic queues
    logic [`FIB_BUCKETS-1:0] model_rows [`FIB_LENGTHS];
    logic [7:0] tx_q[$];
    logic [7:0] exp_q[$];
    logic [7:0] notice_meta_q[$];
    logic [`FIB_PREFIX_W-1:0] notice_prefix_q[$];
    logic [`FIB_PREFIX_W-1:0] learned [20];
    int errors;
    int checks;
    int run_len;
    logic [31:0] lcg_state;

    fib_top u_fib_top (
        .clk(clk),
        .rst(rst),
        .rx_valid(rx_valid),
        .rx_byte(rx_byte),
        .notice_valid(notice_valid),
        .notice_metadata(notice_metadata),
        .notice_prefix(notice_prefix),
        .lookup_valid(lookup_valid),
        .lookup_ready(lookup_ready),
        .lookup_metadata(lookup_metadata),
        .lookup_prefix(lookup_prefix),
        .tx_valid(tx_valid),
        .tx_byte(tx_byte)
    );

    always #5 clk = ~clk;

    // Key keeps only the top len bits
    function automatic logic [63:0] key_of(input logic [63:0] prefix, input logic [5:0] len);
        logic [63:0] key;
        for (int b = 0; b < 64; b++) begin
            key[b] = prefix[b] && (b >= 64 - int'(len));
        end
        return key;
    endfunction

    // Bit b of the key lands on bucket bit b mod 10
    function automatic logic [9:0] bucket_of(input logic [63:0] key);
        logic [9:0] h;
        h = '0;
        for (int b = 0; b < 64; b++) begin
            h[b % 10] = h[b % 10] ^ key[b];
        end
        return h;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Walk lengths downward and queue the 17 expected bytes
    function automatic void predict(input logic [7:0] meta, input logic [63:0] prefix);
        logic [63:0] key;
        logic [63:0] match;
        logic [5:0] hit_len;
        logic hit;
        hit = 1'b0;
        hit_len = '0;
        match = '0;
        for (int len = int'(meta[5:0]); len >= 0 && !hit; len--) begin
            key = key_of(prefix, 6'(len));
            if (model_rows[len][bucket_of(key)]) begin
                hit = 1'b1;
                hit_len = 6'(len);
                match = key;
            end
        end
        exp_q.push_back({meta[7:6], hit_len});
        for (int i = 7; i >= 0; i--) begin
            exp_q.push_back(prefix[i*8 +: 8]);
        end
        for (int i = 7; i >= 0; i--) begin
            exp_q.push_back(match[i*8 +: 8]);
        end
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Metadata then prefix MSB first, optional idle gaps in rx_valid
    task automatic send_packet(input string name, input logic [7:0] meta,
                               input logic [63:0] prefix, input bit gaps);
        int wait_cycles;
        for (int i = 0; i < 9; i++) begin
            rx_valid = 1'b1;
            rx_byte = (i == 0) ? meta : prefix[(8 - i) * 8 +: 8];
            step();
            if (gaps && i % 3 == 1) begin
                rx_valid = 1'b0;
                rx_byte = 8'h00;
                step();
            end
        end
        rx_valid = 1'b0;
        model_rows[meta[5:0]][bucket_of(key_of(prefix, meta[5:0]))] = 1'b1;
        wait_cycles = 0;
        while (notice_meta_q.size() == 0 && wait_cycles < packet_cycles) begin
            step();
            wait_cycles++;
        end
        // Quiet cycles catch a duplicate notice
        step();
        step();
        checks++;
        assert (notice_meta_q.size() == 1) else begin
            errors++;
            $display("%s: wanted one notice but saw %0d", name, notice_meta_q.size());
        end
        if (notice_meta_q.size() > 0) begin
            check_value({name, " notice metadata"}, 64'(meta), 64'(notice_meta_q[0]));
            check_value({name, " notice prefix"}, prefix, notice_prefix_q[0]);
        end
        notice_meta_q.delete();
        notice_prefix_q.delete();
    endtask

    task automatic request_lookup(input string name, input logic [7:0] meta,
                                  input logic [63:0] prefix);
        int wait_cycles;
        wait_cycles = 0;
        while (!lookup_ready && wait_cycles < lookup_cycles) begin
            step();
            wait_cycles++;
        end
        checks++;
        assert (lookup_ready) else begin
            errors++;
            $display("%s: lookup_ready never came back high", name);
        end
        lookup_valid = 1'b1;
        lookup_metadata = meta;
        lookup_prefix = prefix;
        step();
        lookup_valid = 1'b0;
        predict(meta, prefix);
    endtask

    // Wait for every queued byte, then compare in order
    task automatic check_streams(input string name);
        int wait_cycles;
        logic [7:0] want;
        logic [7:0] got;
        wait_cycles = 0;
        while (tx_q.size() < exp_q.size() && wait_cycles < 2 * lookup_cycles) begin
            step();
            wait_cycles++;
        end
        checks++;
        assert (tx_q.size() >= exp_q.size()) else begin
            errors++;
            $display("%s: result stream stopped after %0d of %0d bytes",
                     name, tx_q.size(), exp_q.size());
        end
        while (exp_q.size() > 0 && tx_q.size() > 0) begin
            want = exp_q.pop_front();
            got = tx_q.pop_front();
            check_value({name, " tx byte"}, 64'(want), 64'(got));
        end
        exp_q.delete();
    endtask

    task automatic test_reset_state();
        check_value("reset tx_valid", 64'(0), 64'(tx_valid));
        check_value("reset notice_valid", 64'(0), 64'(notice_valid));
        check_value("reset lookup_ready", 64'(1), 64'(lookup_ready));
    endtask

    task automatic test_empty_lookup();
        request_lookup("empty lookup", 8'hC5, 64'h0123_4567_89AB_CDEF);
        check_streams("empty lookup");
    endtask

    task automatic test_notice();
        send_packet("notice", 8'h50, 64'hFEED_BEEF_0BAD_F00D, 1'b0);
        send_packet("notice gaps", 8'h0C, 64'h1357_9BDF_2468_ACE0, 1'b1);
    endtask

    // Rows 25..48 stay empty, so the walk must stop at 24
    task automatic test_extend_match();
        int wait_cycles;
        send_packet("learn 24", 8'd24, 64'hA1B2_C3FF_FFFF_FFFF, 1'b0);
        request_lookup("extend", {2'b10, 6'd48}, 64'hA1B2_C3D4_E5F6_0718);
        wait_cycles = 0;
        while (tx_q.size() < 17 && wait_cycles < lookup_cycles) begin
            step();
            wait_cycles++;
        end
        // Length 24 with the flag bits kept, match is the top three bytes
        if (tx_q.size() >= 17) begin
            check_value("extend metadata", 64'h98, 64'(tx_q[0]));
            check_value("extend match prefix", 64'hA1B2_C300_0000_0000,
                        {tx_q[9], tx_q[10], tx_q[11], tx_q[12],
                         tx_q[13], tx_q[14], tx_q[15], tx_q[16]});
        end
        check_streams("extend");
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [7:0] meta;
        logic [63:0] prefix;
        for (int i = 0; i < 20; i++) begin
            r = lcg_next();
            // Lengths 4 and up, so length 0 never matches everything
            meta = {r[7:6], r[13:8] | 6'd4};
            prefix[63:32] = lcg_next();
            prefix[31:0] = lcg_next();
            learned[i] = prefix;
            send_packet("random learn", meta, prefix, i % 4 == 0);
        end
        for (int i = 0; i < 20; i++) begin
            r = lcg_next();
            if (i % 2 == 0) begin
                // Learned prefix with low bits disturbed
                prefix = learned[i] ^ {32'h0, lcg_next()};
                meta = {r[1:0], 6'd63};
            end else begin
                prefix[63:32] = lcg_next();
                prefix[31:0] = lcg_next();
                meta = {r[1:0], r[13:8]};
            end
            request_lookup("random lookup", meta, prefix);
            check_streams("random lookup");
        end
    endtask

    task automatic test_back_to_back();
        request_lookup("back to back first", 8'h7F, learned[3]);
        check_value("back to back ready low", 64'(0), 64'(lookup_ready));
        request_lookup("back to back second", 8'hBF, learned[6]);
        check_streams("back to back");
    endtask

    // Outputs sampled on the falling edge where they are settled
    always @(negedge clk) begin
        if (notice_valid) begin
            notice_meta_q.push_back(notice_metadata);
            notice_prefix_q.push_back(notice_prefix);
        end
        if (tx_valid) begin
            tx_q.push_back(tx_byte);
            run_len++;
        end else if (run_len != 0) begin
            checks++;
            assert (run_len == 17) else begin
                errors++;
                $display("tx stream lasted %0d cycles instead of 17", run_len);
            end
            run_len = 0;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rx_valid = 1'b0;
        rx_byte = 8'h00;
        lookup_valid = 1'b0;
        lookup_metadata = 8'h00;
        lookup_prefix = '0;
        errors = 0;
        checks = 0;
        run_len = 0;
        lcg_state = 32'h3606_2f96;
        for (int i = 0; i < `FIB_LENGTHS; i++) begin
            model_rows[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        // Empty-table lookup runs before anything is learned
        test_empty_lookup();
        test_notice();
        test_extend_match();
        test_random();
        test_back_to_back();
        repeat (4) step();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fib_top.sv ====
//############################
// Top level of the FIB block
// Receive stream learns, lookups stream results out
//############################
`include "fib_params.svh"
`default_nettype none

module fib_top (
    input  logic clk,
    input  logic rst,
    // Incoming packet bytes
    input  logic rx_valid,
    input  logic [7:0] rx_byte,
    // Notice to the pending-interest side
    output logic notice_valid,
    output logic [7:0] notice_metadata,
    output logic [`FIB_PREFIX_W-1:0] notice_prefix,
    // Lookup request
    input  logic lookup_valid,
    output logic lookup_ready,
    input  logic [7:0] lookup_metadata,
    input  logic [`FIB_PREFIX_W-1:0] lookup_prefix,
    // Result stream
    output logic tx_valid,
    output logic [7:0] tx_byte
);

    logic learn_valid;
    logic [`FIB_LEN_W-1:0] learn_length;
    logic [`FIB_HASH_W-1:0] learn_bucket;

    fib_probe_if u_probe_if ();
    fib_result_if u_result_if ();

    fib_rx_parser u_rx_parser (
        .clk(clk),
        .rst(rst),
        .rx_valid(rx_valid),
        .rx_byte(rx_byte),
        .learn_valid(learn_valid),
        .learn_length(learn_length),
        .learn_bucket(learn_bucket),
        .notice_valid(notice_valid),
        .notice_metadata(notice_metadata),
        .notice_prefix(notice_prefix)
    );

    fib_bitmap_table u_bitmap_table (
        .clk(clk),
        .rst(rst),
        .learn_valid(learn_valid),
        .learn_length(learn_length),
        .learn_bucket(learn_bucket),
        .probe(u_probe_if.target)
    );

    fib_lpm_engine u_lpm_engine (
        .clk(clk),
        .rst(rst),
        .lookup_valid(lookup_valid),
        .lookup_ready(lookup_ready),
        .lookup_metadata(lookup_metadata),
        .lookup_prefix(lookup_prefix),
        .probe(u_probe_if.initiator),
        .result(u_result_if.source)
    );

    fib_tx_serializer u_tx_serializer (
        .clk(clk),
        .rst(rst),
        .result(u_result_if.sink),
        .tx_valid(tx_valid),
        .tx_byte(tx_byte)
    );

endmodule

`default_nettype wire

// ==== fib_tx_serializer.sv ====
//############################
// Turns one lookup result into a 17-byte stream
// Metadata, request prefix, then matched prefix
//############################
`include "fib_params.svh"
`default_nettype none

module fib_tx_serializer (
    input  logic clk,
    input  logic rst,
    fib_result_if.sink result,
    output logic tx_valid,
    output logic [7:0] tx_byte
);

    localparam logic [2:0] last_idx = 3'(`FIB_PREFIX_BYTES - 1);

    fib_pkg::tx_state_t state;
    logic [2:0] byte_cnt;
    logic [7:0] meta_q;
    logic [`FIB_PREFIX_W-1:0] req_sr;
    logic [`FIB_PREFIX_W-1:0] match_sr;
    logic take;

    // Only an idle serializer accepts a new result
    assign result.result_ready = (state == fib_pkg::tx_idle);
    assign take = result.result_valid && result.result_ready;

    assign tx_valid = (state != fib_pkg::tx_idle);

    always_comb begin
        case (state)
            fib_pkg::tx_meta: tx_byte = meta_q;
            fib_pkg::tx_request: tx_byte = req_sr[`FIB_PREFIX_W-1 -: 8];
            fib_pkg::tx_match: tx_byte = match_sr[`FIB_PREFIX_W-1 -: 8];
            default: tx_byte = 8'h00;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fib_pkg::tx_idle;
            byte_cnt <= '0;
        end else begin
            case (state)
                fib_pkg::tx_idle: begin
                    if (take) begin
                        state <= fib_pkg::tx_meta;
                    end
                end
                fib_pkg::tx_meta: begin
                    byte_cnt <= '0;
                    state <= fib_pkg::tx_request;
                end
                // Eight bytes each, counter wraps back to 0 at the end
                fib_pkg::tx_request: begin
                    byte_cnt <= byte_cnt + 3'd1;
                    if (byte_cnt == last_idx) begin
                        state <= fib_pkg::tx_match;
                    end
                end
                fib_pkg::tx_match: begin
                    byte_cnt <= byte_cnt + 3'd1;
                    if (byte_cnt == last_idx) begin
                        state <= fib_pkg::tx_idle;
                    end
                end
                default: state <= fib_pkg::tx_idle;
            endcase
        end
    end

    // Shift out MSB first
    always_ff @(posedge clk) begin
        if (take) begin
            meta_q <= result.result_metadata;
            req_sr <= result.result_request_prefix;
            match_sr <= result.result_match_prefix;
        end
        if (state == fib_pkg::tx_request) begin
            req_sr <= req_sr << 8;
        end
        if (state == fib_pkg::tx_match) begin
            match_sr <= match_sr << 8;
        end
    end

endmodule

`default_nettype wire

// ==== fib_lpm_engine.sv ====
//############################
// Longest-prefix-match lookup engine
// Probes the requested length, then each shorter one down to 0
// Result is held on a valid/ready link to the serializer
//############################
`include "fib_params.svh"
`default_nettype none

module fib_lpm_engine (
    input  logic clk,
    input  logic rst,
    input  logic lookup_valid,
    output logic lookup_ready,
    input  logic [7:0] lookup_metadata,
    input  logic [`FIB_PREFIX_W-1:0] lookup_prefix,
    fib_probe_if.initiator probe,
    fib_result_if.source result
);

    fib_pkg::lpm_state_t state;
    logic [`FIB_LEN_W-1:0] cur_len;
    logic [7:0] req_meta;
    logic [`FIB_PREFIX_W-1:0] req_prefix;
    logic [`FIB_PREFIX_W-1:0] masked_key;
    logic probe_done;

    // Key for the length under test, also the matched prefix on a hit
    assign masked_key = fib_pkg::fib_mask(req_prefix, cur_len);

    assign lookup_ready = (state == fib_pkg::lpm_idle);

    // One probe per visit to the probe state
    assign probe.probe_valid = (state == fib_pkg::lpm_probe);
    assign probe.probe_length = cur_len;
    assign probe.probe_bucket = fib_pkg::fib_hash(masked_key);

    // Stop on a hit or after length 0 has been tried
    assign probe_done = probe.probe_hit || (cur_len == '0);

    assign result.result_valid = (state == fib_pkg::lpm_result);
    assign result.result_request_prefix = req_prefix;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fib_pkg::lpm_idle;
        end else begin
            case (state)
                fib_pkg::lpm_idle: begin
                    if (lookup_valid) begin
                        state <= fib_pkg::lpm_probe;
                    end
                end
                fib_pkg::lpm_probe: state <= fib_pkg::lpm_wait;
                // probe_hit is valid here, a cycle after the probe
                fib_pkg::lpm_wait: begin
                    state <= probe_done ? fib_pkg::lpm_result : fib_pkg::lpm_probe;
                end
                fib_pkg::lpm_result: begin
                    if (result.result_ready) begin
                        state <= fib_pkg::lpm_idle;
                    end
                end
                default: state <= fib_pkg::lpm_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fib_pkg::lpm_idle && lookup_valid) begin
            req_meta <= lookup_metadata;
            req_prefix <= lookup_prefix;
            cur_len <= lookup_metadata[`FIB_META_LEN_MSB:0];
        end
        if (state == fib_pkg::lpm_wait) begin
            if (!probe_done) begin
                cur_len <= cur_len - 1'b1;
            end else begin
                // Flag bits pass through, length is 0 on a miss
                result.result_metadata <= {req_meta[7:6],
                    probe.probe_hit ? cur_len : {`FIB_LEN_W{1'b0}}};
                result.result_match_prefix <= probe.probe_hit ? masked_key : '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== fib_bitmap_table.sv ====
//############################
// Valid-bit table, one row of buckets per prefix length
// One learn write port, one registered probe read port
//############################
`include "fib_params.svh"
`default_nettype none

module fib_bitmap_table (
    input  logic clk,
    input  logic rst,
    input  logic learn_valid,
    input  logic [`FIB_LEN_W-1:0] learn_length,
    input  logic [`FIB_HASH_W-1:0] learn_bucket,
    fib_probe_if.target probe
);

    // 64 rows of 1024 bits
    logic [`FIB_BUCKETS-1:0] valid_bits [`FIB_LENGTHS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Table starts empty
            for (int i = 0; i < `FIB_LENGTHS; i++) begin
                valid_bits[i] <= '0;
            end
            probe.probe_hit <= 1'b0;
        end else begin
            if (learn_valid) begin
                valid_bits[learn_length][learn_bucket] <= 1'b1;
            end
            // Nonblocking read sees the value before a same-edge write
            probe.probe_hit <= probe.probe_valid &&
                valid_bits[probe.probe_length][probe.probe_bucket];
        end
    end

endmodule

`default_nettype wire

// ==== fib_rx_parser.sv ====
//############################
// Packet assembler for the receive stream
// Emits one learn write and one notice per packet
//############################
`include "fib_params.svh"
`default_nettype none

module fib_rx_parser (
    input  logic clk,
    input  logic rst,
    input  logic rx_valid,
    input  logic [7:0] rx_byte,
    output logic learn_valid,
    output logic [`FIB_LEN_W-1:0] learn_length,
    output logic [`FIB_HASH_W-1:0] learn_bucket,
    output logic notice_valid,
    output logic [7:0] notice_metadata,
    output logic [`FIB_PREFIX_W-1:0] notice_prefix
);

    localparam logic [2:0] last_idx = 3'(`FIB_PREFIX_BYTES - 1);

    fib_pkg::rx_state_t state;
    logic [2:0] byte_cnt;
    logic [7:0] meta_q;
    logic [`FIB_PREFIX_W-1:0] prefix_sr;
    logic [`FIB_PREFIX_W-1:0] prefix_next;
    logic last_byte;

    // Prefix arrives most significant byte first
    assign prefix_next = {prefix_sr[`FIB_PREFIX_W-9:0], rx_byte};
    assign last_byte = rx_valid && (state == fib_pkg::rx_prefix) && (byte_cnt == last_idx);

    // Learn and notice last exactly the one cycle spent in the learn state
    assign learn_valid = (state == fib_pkg::rx_learn);
    assign notice_valid = (state == fib_pkg::rx_learn);
    assign learn_length = notice_metadata[`FIB_META_LEN_MSB:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fib_pkg::rx_idle;
            byte_cnt <= '0;
        end else begin
            case (state)
                // Learn cycle can already take the next metadata byte
                fib_pkg::rx_idle, fib_pkg::rx_learn: begin
                    byte_cnt <= '0;
                    state <= rx_valid ? fib_pkg::rx_prefix : fib_pkg::rx_idle;
                end
                fib_pkg::rx_prefix: begin
                    if (rx_valid) begin
                        byte_cnt <= byte_cnt + 3'd1;
                        if (byte_cnt == last_idx) begin
                            state <= fib_pkg::rx_learn;
                        end
                    end
                end
                default: state <= fib_pkg::rx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // Metadata byte is any valid byte outside the prefix phase
        if (rx_valid && state != fib_pkg::rx_prefix) begin
            meta_q <= rx_byte;
        end
        if (rx_valid && state == fib_pkg::rx_prefix) begin
            prefix_sr <= prefix_next;
        end
        // Snapshot for the notice and the table write
        if (last_byte) begin
            notice_metadata <= meta_q;
            notice_prefix <= prefix_next;
            learn_bucket <= fib_pkg::fib_hash(
                fib_pkg::fib_mask(prefix_next, meta_q[`FIB_META_LEN_MSB:0]));
        end
    end

endmodule

`default_nettype wire

// ==== fib_if.sv ====
//############################
// Internal links of the FIB block
// Probe path to the table and result path to the serializer
//############################
`include "fib_params.svh"
`default_nettype none

// Engine asks the table for one valid bit, answer comes a cycle later
interface fib_probe_if;
    logic probe_valid;
    logic [`FIB_LEN_W-1:0] probe_length;
    logic [`FIB_HASH_W-1:0] probe_bucket;
    logic probe_hit;

    modport initiator (
        output probe_valid, probe_length, probe_bucket,
        input probe_hit
    );

    modport target (
        input probe_valid, probe_length, probe_bucket,
        output probe_hit
    );
endinterface

// Valid/ready handoff of a finished lookup
interface fib_result_if;
    logic result_valid;
    logic result_ready;
    logic [7:0] result_metadata;
    logic [`FIB_PREFIX_W-1:0] result_request_prefix;
    logic [`FIB_PREFIX_W-1:0] result_match_prefix;

    modport source (
        output result_valid, result_metadata, result_request_prefix, result_match_prefix,
        input result_ready
    );

    modport sink (
        input result_valid, result_metadata, result_request_prefix, result_match_prefix,
        output result_ready
    );
endinterface

`default_nettype wire

// ==== fib_pkg.sv ====
//############################
// Shared FIB functions and FSM state types
// Referenced as fib_pkg::name by the RTL
//############################
`include "fib_params.svh"
`default_nettype none

package fib_pkg;

    // Clear every bit below the top length bits of the prefix
    function automatic logic [`FIB_PREFIX_W-1:0] fib_mask(
        input logic [`FIB_PREFIX_W-1:0] prefix,
        input logic [`FIB_LEN_W-1:0] length
    );
        logic [`FIB_LEN_W:0] shift;
        logic [`FIB_PREFIX_W-1:0] keep;
        // Shift amount is 64 minus length, so length 0 keeps nothing
        shift = {1'b1, {`FIB_LEN_W{1'b0}}} - {1'b0, length};
        keep = {`FIB_PREFIX_W{1'b1}} << shift;
        return prefix & keep;
    endfunction

    // Fold the key into a bucket by XOR of 10-bit slices from bit 0 upward
    function automatic logic [`FIB_HASH_W-1:0] fib_hash(
        input logic [`FIB_PREFIX_W-1:0] key
    );
        logic [`FIB_HASH_W-1:0] h;
        logic [`FIB_PREFIX_W-1:0] tail;
        h = '0;
        for (int i = 0; i < `FIB_PREFIX_W / `FIB_HASH_W; i++) begin
            h = h ^ key[i*`FIB_HASH_W +: `FIB_HASH_W];
        end
        // Last short slice, zero-extended
        tail = key >> ((`FIB_PREFIX_W / `FIB_HASH_W) * `FIB_HASH_W);
        h = h ^ tail[`FIB_HASH_W-1:0];
        return h;
    endfunction

    // Parser states
    typedef enum logic [1:0] {rx_idle, rx_prefix, rx_learn} rx_state_t;

    // Lookup engine states
    typedef enum logic [1:0] {lpm_idle, lpm_probe, lpm_wait, lpm_result} lpm_state_t;

    // Serializer states
    typedef enum logic [1:0] {tx_idle, tx_meta, tx_request, tx_match} tx_state_t;

endpackage

`default_nettype wire

// ==== fib_params.svh ====
//############################
// Width and size constants for the FIB block
// Include in any file that sizes ports or tables
//############################
`ifndef FIB_PARAMS_SVH
`define FIB_PARAMS_SVH

// Name prefix carried by every packet
`define FIB_PREFIX_W 64
// Prefix length field inside the metadata byte
`define FIB_LEN_W 6
`define FIB_META_LEN_MSB 5

// Bucket index produced by the hash
`define FIB_HASH_W 10
// Valid-bit table geometry, one row of buckets per length
`define FIB_BUCKETS 1024
`define FIB_LENGTHS 64

// Bytes of prefix that follow the metadata byte
`define FIB_PREFIX_BYTES 8

`endif
